// File: Bender.yml
package:
  name: cce

sources:
  - cce_pkg.sv
  - cce_req_ingress.sv
  - cce_directory.sv
  - cce_fsm.sv
  - cce_egress.sv
  - cce_top.sv
  - target: test
    files:
      - cce_assertions.sv
      - tb_cce_top.sv

// File: cce_assertions.sv
// cce assertions: output handshake stability, reset values and memory request ordering
`default_nettype none
`timescale 1ns/1ps

module cce_assertions
  (input  wire logic               clk_i
   , input  wire logic             rst_n_i
   , input  wire logic             lce_req_ready_o
   , input  cce_pkg::lce_cmd_s     lce_cmd_o
   , input  wire logic             lce_cmd_v_o
   , input  wire logic             lce_cmd_ready_i
   , input  cce_pkg::mem_fwd_s     mem_fwd_o
   , input  wire logic             mem_fwd_v_o
   , input  wire logic             mem_fwd_ready_i
   , input  cce_pkg::cce_state_e   fsm_state_i
  );

  int unsigned fail_count = 0;

  cmd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_o))
    else begin
      fail_count++;
      $error("lce_cmd valid or payload changed while stalled");
    end

  fwd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_fwd_v_o && !mem_fwd_ready_i |=> mem_fwd_v_o && $stable(mem_fwd_o))
    else begin
      fail_count++;
      $error("mem_fwd valid or payload changed while stalled");
    end

  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |-> !lce_cmd_v_o && !mem_fwd_v_o && !lce_req_ready_o)
    else begin
      fail_count++;
      $error("valid or ready high during reset");
    end

  // first wait cycle still shows the request that moved the fsm here
  no_fwd_in_wait_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fsm_state_i == cce_pkg::e_mem_wait) && ($past(fsm_state_i) == cce_pkg::e_mem_wait)
    |-> !$rose(mem_fwd_v_o))
    else begin
      fail_count++;
      $error("new memory request while waiting for memory");
    end

endmodule

bind cce_top cce_assertions assert_i
  (.clk_i             (clk_i)
   , .rst_n_i         (rst_n_i)
   , .lce_req_ready_o (lce_req_ready_o)
   , .lce_cmd_o       (lce_cmd_o)
   , .lce_cmd_v_o     (lce_cmd_v_o)
   , .lce_cmd_ready_i (lce_cmd_ready_i)
   , .mem_fwd_o       (mem_fwd_o)
   , .mem_fwd_v_o     (mem_fwd_v_o)
   , .mem_fwd_ready_i (mem_fwd_ready_i)
   , .fsm_state_i     (fsm_i.state_q)
  );

`default_nettype wire

// File: cce_directory.sv
// cce directory: full-map block state and sharer store with a registered read port
`default_nettype none
`timescale 1ns/1ps

module cce_directory
  (input  wire logic                 clk_i
   , input  wire logic               rst_n_i
   , input  wire logic               rd_en_i
   , input  cce_pkg::dir_idx_t       idx_i
   , input  wire logic               wr_en_i
   , input  cce_pkg::dir_entry_s     wr_entry_i
   , output cce_pkg::dir_entry_s     rd_entry_o
  );

  cce_pkg::dir_entry_s dir_mem_q [cce_pkg::dir_sets_gp];
  cce_pkg::dir_entry_s rd_entry_q;

  // every block starts invalid with no sharers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < cce_pkg::dir_sets_gp; i++) begin
        dir_mem_q[i].state   <= cce_pkg::e_dir_i;
        dir_mem_q[i].sharers <= '0;
      end
    end else if (wr_en_i) begin
      dir_mem_q[idx_i] <= wr_entry_i;
    end
  end

  // read data shows up one cycle after rd_en_i
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_entry_q <= dir_mem_q[idx_i];
    end
  end

  assign rd_entry_o = rd_entry_q;

endmodule

`default_nettype wire

// File: cce_egress.sv
// cce egress: one-entry output registers for LCE commands and memory forward requests
`default_nettype none
`timescale 1ns/1ps

module cce_egress
  (input  wire logic               clk_i
   , input  wire logic             rst_n_i
   , input  cce_pkg::lce_cmd_s     cmd_i
   , input  wire logic             cmd_v_i
   , output logic                  cmd_ready_o
   , input  cce_pkg::mem_fwd_s     fwd_i
   , input  wire logic             fwd_v_i
   , output logic                  fwd_ready_o
   , output cce_pkg::lce_cmd_s     lce_cmd_o
   , output logic                  lce_cmd_v_o
   , input  wire logic             lce_cmd_ready_i
   , output cce_pkg::mem_fwd_s     mem_fwd_o
   , output logic                  mem_fwd_v_o
   , input  wire logic             mem_fwd_ready_i
  );

  cce_pkg::lce_cmd_s cmd_q;
  cce_pkg::mem_fwd_s fwd_q;
  logic              cmd_v_q;
  logic              fwd_v_q;

  // load when empty or when the held item leaves this cycle
  assign cmd_ready_o = ~cmd_v_q | lce_cmd_ready_i;
  assign fwd_ready_o = ~fwd_v_q | mem_fwd_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_v_q <= 1'b0;
      fwd_v_q <= 1'b0;
    end else begin
      if (cmd_ready_o) cmd_v_q <= cmd_v_i;
      if (fwd_ready_o) fwd_v_q <= fwd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
    if (fwd_v_i && fwd_ready_o) begin
      fwd_q <= fwd_i;
    end
  end

  assign lce_cmd_o   = cmd_q;
  assign lce_cmd_v_o = cmd_v_q;
  assign mem_fwd_o   = fwd_q;
  assign mem_fwd_v_o = fwd_v_q;

endmodule

`default_nettype wire

// File: cce_fsm.sv
// cce fsm: coherence engine that invalidates, fetches from memory, replies and updates the directory
`default_nettype none
`timescale 1ns/1ps

module cce_fsm
  (input  wire logic                 clk_i
   , input  wire logic               rst_n_i
   , input  cce_pkg::lce_req_s       req_i
   , input  wire logic               req_v_i
   , output logic                    req_ready_o
   , output logic                    dir_rd_en_o
   , output cce_pkg::dir_idx_t       dir_idx_o
   , output logic                    dir_wr_en_o
   , output cce_pkg::dir_entry_s     dir_entry_o
   , input  cce_pkg::dir_entry_s     dir_entry_i
   , output cce_pkg::lce_cmd_s       cmd_o
   , output logic                    cmd_v_o
   , input  wire logic               cmd_ready_i
   , output cce_pkg::mem_fwd_s       fwd_o
   , output logic                    fwd_v_o
   , input  wire logic               fwd_ready_i
   , input  cce_pkg::mem_rev_s       mem_rev_i
   , input  wire logic               mem_rev_v_i
   , output logic                    mem_rev_ready_o
  );

  // lowest set bit of the invalidation set
  function automatic cce_pkg::lce_id_t lowest_id(input cce_pkg::sharers_t vec);
    cce_pkg::lce_id_t id;
    id = '0;
    for (int i = cce_pkg::num_lce_gp - 1; i >= 0; i--) begin
      if (vec[i]) begin
        id = cce_pkg::lce_id_t'(i);
      end
    end
    return id;
  endfunction

  cce_pkg::cce_state_e state_q, state_n;
  cce_pkg::lce_req_s   req_q;
  cce_pkg::sharers_t   inv_q;
  cce_pkg::sharers_t   inv_rest;
  cce_pkg::sharers_t   inv_set;
  cce_pkg::sharers_t   req_bit;
  cce_pkg::dir_entry_s entry_q;
  cce_pkg::dir_entry_s next_entry;
  cce_pkg::data_t      data_q;
  cce_pkg::paddr_t     blk_addr;

  assign blk_addr = {req_q.addr[cce_pkg::paddr_width_gp-1:cce_pkg::block_offset_width_gp],
                     {cce_pkg::block_offset_width_gp{1'b0}}};
  assign inv_rest = inv_q & (inv_q - 1'b1);

  // coherence rules, evaluated while the directory entry is on dir_entry_i
  always_comb begin
    req_bit = '0;
    req_bit[req_q.src_id] = 1'b1;
    inv_set = '0;
    next_entry = dir_entry_i;
    if (req_q.req_type == cce_pkg::e_req_wr) begin
      inv_set = dir_entry_i.sharers & ~req_bit;
      next_entry.state   = cce_pkg::e_dir_e;
      next_entry.sharers = req_bit;
    end else begin
      case (dir_entry_i.state)
        cce_pkg::e_dir_e: begin
          // owner re-reading keeps its exclusive copy
          if ((dir_entry_i.sharers & req_bit) == '0) begin
            inv_set = dir_entry_i.sharers;
            next_entry.state   = cce_pkg::e_dir_s;
            next_entry.sharers = req_bit;
          end
        end
        cce_pkg::e_dir_s: begin
          next_entry.sharers = dir_entry_i.sharers | req_bit;
        end
        default: begin
          next_entry.state   = cce_pkg::e_dir_s;
          next_entry.sharers = req_bit;
        end
      endcase
    end
  end

  always_comb begin
    state_n = state_q;
    case (state_q)
      cce_pkg::e_idle:     if (req_v_i) state_n = cce_pkg::e_lookup;
      cce_pkg::e_lookup:   state_n = (inv_set != '0) ? cce_pkg::e_inv : cce_pkg::e_mem_req;
      cce_pkg::e_inv: begin
        if (cmd_ready_i && (inv_rest == '0)) begin
          state_n = cce_pkg::e_mem_req;
        end
      end
      cce_pkg::e_mem_req:  if (fwd_ready_i) state_n = cce_pkg::e_mem_wait;
      cce_pkg::e_mem_wait: if (mem_rev_v_i) state_n = cce_pkg::e_reply;
      cce_pkg::e_reply:    if (cmd_ready_i) state_n = cce_pkg::e_update;
      default:             state_n = cce_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= cce_pkg::e_idle;
      inv_q   <= '0;
    end else begin
      state_q <= state_n;
      if (state_q == cce_pkg::e_lookup) begin
        inv_q <= inv_set;
      end else if ((state_q == cce_pkg::e_inv) && cmd_ready_i) begin
        inv_q <= inv_rest;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == cce_pkg::e_idle) && req_v_i) begin
      req_q <= req_i;
    end
    if (state_q == cce_pkg::e_lookup) begin
      entry_q <= next_entry;
    end
    if ((state_q == cce_pkg::e_mem_wait) && mem_rev_v_i) begin
      data_q <= mem_rev_i.data;
    end
  end

  assign req_ready_o = (state_q == cce_pkg::e_idle);

  // lookup is issued on the accepting cycle, so index comes straight from req_i
  assign dir_rd_en_o = (state_q == cce_pkg::e_idle) & req_v_i;
  assign dir_idx_o   = (state_q == cce_pkg::e_idle)
                     ? req_i.addr[cce_pkg::paddr_width_gp-1:cce_pkg::block_offset_width_gp]
                     : req_q.addr[cce_pkg::paddr_width_gp-1:cce_pkg::block_offset_width_gp];
  assign dir_wr_en_o = (state_q == cce_pkg::e_update);
  assign dir_entry_o = entry_q;

  assign cmd_v_o = (state_q == cce_pkg::e_inv) | (state_q == cce_pkg::e_reply);
  always_comb begin
    cmd_o.addr = blk_addr;
    if (state_q == cce_pkg::e_inv) begin
      cmd_o.cmd_type = cce_pkg::e_cmd_inv;
      cmd_o.dst_id   = lowest_id(inv_q);
      cmd_o.data     = '0;
    end else begin
      cmd_o.cmd_type = (req_q.req_type == cce_pkg::e_req_wr) ? cce_pkg::e_cmd_data_e
                                                              : cce_pkg::e_cmd_data_s;
      cmd_o.dst_id   = req_q.src_id;
      cmd_o.data     = data_q;
    end
  end

  assign fwd_v_o         = (state_q == cce_pkg::e_mem_req);
  assign fwd_o.addr      = blk_addr;
  assign mem_rev_ready_o = (state_q == cce_pkg::e_mem_wait);

endmodule

`default_nettype wire

// File: cce_golden.txt
# R <0 read, 1 write> <lce id> <addr hex>, followed by the commands it must produce
# C <0 inv, 1 data_s, 2 data_e> <dst lce id> <block addr hex>
R 0 0 041
C 1 0 040
R 0 1 040
C 1 1 040
R 0 3 07f
C 1 3 040
R 1 2 040
C 0 0 040
C 0 1 040
C 0 3 040
C 2 2 040
R 0 1 040
C 0 2 040
C 1 1 040
R 1 3 0c0
C 2 3 0c0
R 0 3 0c8
C 1 3 0c0
R 0 0 0c0
C 0 3 0c0
C 1 0 0c0
R 1 0 0c0
C 2 0 0c0
R 1 1 200
C 2 1 200
R 1 2 200
C 0 1 200
C 2 2 200
R 0 2 3ff
C 1 2 3c0

// File: cce_pkg.sv
// cce package: widths, opcodes, states and message formats of the coherence engine
`default_nettype none

package cce_pkg;

  localparam int num_lce_gp            = 4;
  localparam int lce_id_width_gp       = 2;
  localparam int paddr_width_gp        = 10;
  localparam int block_offset_width_gp = 6;
  localparam int dir_sets_gp           = 16;
  localparam int data_width_gp         = 64;

  // one directory entry per block, index is the block number
  localparam int dir_idx_width_gp      = paddr_width_gp - block_offset_width_gp;

  typedef logic [lce_id_width_gp-1:0]  lce_id_t;
  typedef logic [paddr_width_gp-1:0]   paddr_t;
  typedef logic [dir_idx_width_gp-1:0] dir_idx_t;
  typedef logic [num_lce_gp-1:0]       sharers_t;
  typedef logic [data_width_gp-1:0]    data_t;

  // read shared or read exclusive
  typedef enum logic {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_cmd_inv    = 2'b00,
    e_cmd_data_s = 2'b01,
    e_cmd_data_e = 2'b10
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    e_dir_i = 2'b00,
    e_dir_s = 2'b01,
    e_dir_e = 2'b10
  } dir_state_e;

  typedef enum logic [2:0] {
    e_idle     = 3'd0,
    e_lookup   = 3'd1,
    e_inv      = 3'd2,
    e_mem_req  = 3'd3,
    e_mem_wait = 3'd4,
    e_reply    = 3'd5,
    e_update   = 3'd6
  } cce_state_e;

  typedef struct packed {
    lce_req_type_e req_type;
    lce_id_t       src_id;
    paddr_t        addr;
  } lce_req_s;

  typedef struct packed {
    lce_cmd_type_e cmd_type;
    lce_id_t       dst_id;
    paddr_t        addr;
    data_t         data;
  } lce_cmd_s;

  typedef struct packed {
    paddr_t addr;
  } mem_fwd_s;

  typedef struct packed {
    paddr_t addr;
    data_t  data;
  } mem_rev_s;

  typedef struct packed {
    dir_state_e state;
    sharers_t   sharers;
  } dir_entry_s;

endpackage

`default_nettype wire

// File: cce_req_ingress.sv
// cce request ingress: two-entry skid buffer between the LCE request channel and the engine
`default_nettype none
`timescale 1ns/1ps

module cce_req_ingress
  (input  wire logic               clk_i
   , input  wire logic             rst_n_i
   , input  cce_pkg::lce_req_s     lce_req_i
   , input  wire logic             lce_req_v_i
   , output logic                  lce_req_ready_o
   , output cce_pkg::lce_req_s     req_o
   , output logic                  req_v_o
   , input  wire logic             req_ready_i
  );

  cce_pkg::lce_req_s slot0_q;
  cce_pkg::lce_req_s slot1_q;
  logic [1:0]        cnt_q;
  logic [1:0]        cnt_n;
  logic              ready_q;
  logic              push;
  logic              pop;

  assign push = lce_req_v_i & ready_q;
  assign pop  = req_v_o & req_ready_i;
  assign cnt_n = cnt_q + {1'b0, push} - {1'b0, pop};

  // head of the buffer is always slot0
  assign req_o           = slot0_q;
  assign req_v_o         = (cnt_q != 2'd0);
  assign lce_req_ready_o = ready_q;

  // ready comes from a flop, low while in reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= 2'd0;
      ready_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_n;
      ready_q <= (cnt_n != 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      slot0_q <= (cnt_q == 2'd2) ? slot1_q : lce_req_i;
      slot1_q <= lce_req_i;
    end else if (push) begin
      if (cnt_q == 2'd0) begin
        slot0_q <= lce_req_i;
      end else begin
        slot1_q <= lce_req_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: cce_top.f
cce_pkg.sv
cce_req_ingress.sv
cce_directory.sv
cce_fsm.sv
cce_egress.sv
cce_top.sv
cce_assertions.sv
tb_cce_top.sv

// File: cce_top.sv
// cce top level: request ingress, coherence fsm, directory and output registers
`default_nettype none
`timescale 1ns/1ps

module cce_top
  (input  wire logic               clk_i
   , input  wire logic             rst_n_i
   , input  cce_pkg::lce_req_s     lce_req_i
   , input  wire logic             lce_req_v_i
   , output logic                  lce_req_ready_o
   , output cce_pkg::lce_cmd_s     lce_cmd_o
   , output logic                  lce_cmd_v_o
   , input  wire logic             lce_cmd_ready_i
   , output cce_pkg::mem_fwd_s     mem_fwd_o
   , output logic                  mem_fwd_v_o
   , input  wire logic             mem_fwd_ready_i
   , input  cce_pkg::mem_rev_s     mem_rev_i
   , input  wire logic             mem_rev_v_i
   , output logic                  mem_rev_ready_o
  );

  cce_pkg::lce_req_s   req;
  logic                req_v;
  logic                req_ready;
  logic                dir_rd_en;
  cce_pkg::dir_idx_t   dir_idx;
  logic                dir_wr_en;
  cce_pkg::dir_entry_s dir_wr_entry;
  cce_pkg::dir_entry_s dir_rd_entry;
  cce_pkg::lce_cmd_s   cmd;
  logic                cmd_v;
  logic                cmd_ready;
  cce_pkg::mem_fwd_s   fwd;
  logic                fwd_v;
  logic                fwd_ready;

  cce_req_ingress ingress_i
    (.clk_i           (clk_i)
     , .rst_n_i         (rst_n_i)
     , .lce_req_i       (lce_req_i)
     , .lce_req_v_i     (lce_req_v_i)
     , .lce_req_ready_o (lce_req_ready_o)
     , .req_o           (req)
     , .req_v_o         (req_v)
     , .req_ready_i     (req_ready)
    );

  cce_fsm fsm_i
    (.clk_i             (clk_i)
     , .rst_n_i         (rst_n_i)
     , .req_i           (req)
     , .req_v_i         (req_v)
     , .req_ready_o     (req_ready)
     , .dir_rd_en_o     (dir_rd_en)
     , .dir_idx_o       (dir_idx)
     , .dir_wr_en_o     (dir_wr_en)
     , .dir_entry_o     (dir_wr_entry)
     , .dir_entry_i     (dir_rd_entry)
     , .cmd_o           (cmd)
     , .cmd_v_o         (cmd_v)
     , .cmd_ready_i     (cmd_ready)
     , .fwd_o           (fwd)
     , .fwd_v_o         (fwd_v)
     , .fwd_ready_i     (fwd_ready)
     , .mem_rev_i       (mem_rev_i)
     , .mem_rev_v_i     (mem_rev_v_i)
     , .mem_rev_ready_o (mem_rev_ready_o)
    );

  cce_directory dir_i
    (.clk_i        (clk_i)
     , .rst_n_i    (rst_n_i)
     , .rd_en_i    (dir_rd_en)
     , .idx_i      (dir_idx)
     , .wr_en_i    (dir_wr_en)
     , .wr_entry_i (dir_wr_entry)
     , .rd_entry_o (dir_rd_entry)
    );

  cce_egress egress_i
    (.clk_i             (clk_i)
     , .rst_n_i         (rst_n_i)
     , .cmd_i           (cmd)
     , .cmd_v_i         (cmd_v)
     , .cmd_ready_o     (cmd_ready)
     , .fwd_i           (fwd)
     , .fwd_v_i         (fwd_v)
     , .fwd_ready_o     (fwd_ready)
     , .lce_cmd_o       (lce_cmd_o)
     , .lce_cmd_v_o     (lce_cmd_v_o)
     , .lce_cmd_ready_i (lce_cmd_ready_i)
     , .mem_fwd_o       (mem_fwd_o)
     , .mem_fwd_v_o     (mem_fwd_v_o)
     , .mem_fwd_ready_i (mem_fwd_ready_i)
    );

endmodule

`default_nettype wire

// File: tb_cce_top.sv
// cce testbench: golden-file requests, memory model, random back-pressure and command checks
`default_nettype none
`timescale 1ns/1ps

module tb_cce_top;

  localparam int          reset_cycles_lp   = 10;
  localparam int          cycles_per_req_lp = 200;
  localparam int          drain_cycles_lp   = 10;
  localparam logic [31:0] seed_lp           = 32'h0e4c_ce84;

  logic                clk_i;
  logic                rst_n_i;
  cce_pkg::lce_req_s   lce_req_i;
  logic                lce_req_v_i;
  logic                lce_req_ready_o;
  cce_pkg::lce_cmd_s   lce_cmd_o;
  logic                lce_cmd_v_o;
  logic                lce_cmd_ready_i;
  cce_pkg::mem_fwd_s   mem_fwd_o;
  logic                mem_fwd_v_o;
  logic                mem_fwd_ready_i;
  cce_pkg::mem_rev_s   mem_rev_i;
  logic                mem_rev_v_i;
  logic                mem_rev_ready_o;

  cce_pkg::lce_req_s   reqs[$];
  cce_pkg::lce_cmd_s   exp_cmds[$];
  cce_pkg::paddr_t     exp_fwds[$];
  cce_pkg::paddr_t     mem_pending[$];
  int                  mem_delay;
  int                  req_idx;
  logic                req_fire;
  logic                rev_fire;
  logic [31:0]         rng;
  int                  error_count;
  int                  check_count;
  int                  cycle_count;
  int                  cycle_limit;

  cce_top dut_i
    (.clk_i             (clk_i)
     , .rst_n_i         (rst_n_i)
     , .lce_req_i       (lce_req_i)
     , .lce_req_v_i     (lce_req_v_i)
     , .lce_req_ready_o (lce_req_ready_o)
     , .lce_cmd_o       (lce_cmd_o)
     , .lce_cmd_v_o     (lce_cmd_v_o)
     , .lce_cmd_ready_i (lce_cmd_ready_i)
     , .mem_fwd_o       (mem_fwd_o)
     , .mem_fwd_v_o     (mem_fwd_v_o)
     , .mem_fwd_ready_i (mem_fwd_ready_i)
     , .mem_rev_i       (mem_rev_i)
     , .mem_rev_v_i     (mem_rev_v_i)
     , .mem_rev_ready_o (mem_rev_ready_o)
    );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory contents of a block, two chained xorshift steps
  function automatic cce_pkg::data_t block_data(input cce_pkg::paddr_t addr);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = next_rand(seed_lp ^ {22'd0, addr});
    hi = next_rand(lo);
    return {hi, lo};
  endfunction

  function automatic logic all_done();
    return (req_idx == reqs.size()) && (exp_cmds.size() == 0)
           && (exp_fwds.size() == 0) && (mem_pending.size() == 0);
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic load_golden();
    int                fd;
    int                n;
    int                f1;
    int                f2;
    int                f3;
    logic [7:0]        kind;
    string             line;
    cce_pkg::lce_req_s req;
    cce_pkg::lce_cmd_s cmd;
    fd = $fopen("cce_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open cce_golden.txt for reading");
      error_count++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%c %d %d %h", kind, f1, f2, f3);
      if (kind == "#" || line.len() < 3) begin
        continue;
      end
      if (n != 4 || (kind != "R" && kind != "C")) begin
        $display("malformed golden line: %s", line);
        error_count++;
      end else if (kind == "R") begin
        req.req_type = cce_pkg::lce_req_type_e'(f1[0]);
        req.src_id   = f2[1:0];
        req.addr     = f3[9:0];
        reqs.push_back(req);
        // one memory read per request, at the block address
        exp_fwds.push_back({req.addr[9:6], 6'd0});
      end else begin
        cmd.cmd_type = cce_pkg::lce_cmd_type_e'(f1[1:0]);
        cmd.dst_id   = f2[1:0];
        cmd.addr     = f3[9:0];
        cmd.data     = (cmd.cmd_type == cce_pkg::e_cmd_inv) ? '0 : block_data(cmd.addr);
        exp_cmds.push_back(cmd);
      end
    end
    $fclose(fd);
  endtask

  // one falling edge: retire last edge's transfers, drive, check what the next edge takes
  task automatic service_cycle();
    cce_pkg::lce_cmd_s exp_cmd;
    cce_pkg::paddr_t   exp_addr;
    if (req_fire) begin
      req_idx++;
    end
    if (rev_fire) begin
      mem_pending.delete(0);
      mem_rev_v_i = 1'b0;
    end

    if (req_idx < reqs.size()) begin
      lce_req_i   = reqs[req_idx];
      lce_req_v_i = 1'b1;
    end else begin
      lce_req_v_i = 1'b0;
    end
    rng             = next_rand(rng);
    lce_cmd_ready_i = (rng[1:0] != 2'b00);
    rng             = next_rand(rng);
    mem_fwd_ready_i = rng[0] | rng[1];

    if (!mem_rev_v_i && (mem_pending.size() > 0)) begin
      if (mem_delay > 0) begin
        mem_delay--;
      end else begin
        mem_rev_v_i    = 1'b1;
        mem_rev_i.addr = mem_pending[0];
        mem_rev_i.data = block_data(mem_pending[0]);
      end
    end

    // the engine is waiting for memory whenever a response is offered
    if (mem_rev_v_i) begin
      check_equal(mem_rev_ready_o, 1'b1, "mem_rev_ready_o with a read outstanding");
    end

    req_fire = lce_req_v_i && lce_req_ready_o;
    rev_fire = mem_rev_v_i && mem_rev_ready_o;

    if (lce_cmd_v_o && lce_cmd_ready_i) begin
      if (exp_cmds.size() == 0) begin
        $display("unexpected command to LCE %0d at %0t ns", lce_cmd_o.dst_id, $time);
        error_count++;
      end else begin
        exp_cmd = exp_cmds.pop_front();
        check_equal(lce_cmd_o.cmd_type, exp_cmd.cmd_type, "command type");
        check_equal(lce_cmd_o.dst_id, exp_cmd.dst_id, "command destination");
        check_equal(lce_cmd_o.addr, exp_cmd.addr, "command address");
        if (exp_cmd.cmd_type != cce_pkg::e_cmd_inv) begin
          check_equal(lce_cmd_o.data, exp_cmd.data, "command data");
        end
      end
    end

    if (mem_fwd_v_o && mem_fwd_ready_i) begin
      if (exp_fwds.size() == 0) begin
        $display("unexpected memory read of %h at %0t ns", mem_fwd_o.addr, $time);
        error_count++;
      end else begin
        exp_addr = exp_fwds.pop_front();
        check_equal(mem_fwd_o.addr, exp_addr, "memory read address");
      end
      mem_pending.push_back(mem_fwd_o.addr);
      rng       = next_rand(rng);
      mem_delay = rng[2:0];
    end
  endtask

  initial begin : main
    rst_n_i         = 1'b0;
    lce_req_i       = '0;
    lce_req_v_i     = 1'b0;
    lce_cmd_ready_i = 1'b0;
    mem_fwd_ready_i = 1'b0;
    mem_rev_i       = '0;
    mem_rev_v_i     = 1'b0;
    error_count     = 0;
    check_count     = 0;
    req_idx         = 0;
    req_fire        = 1'b0;
    rev_fire        = 1'b0;
    mem_delay       = 0;
    rng             = seed_lp;

    load_golden();
    cycle_limit = cycles_per_req_lp * reqs.size() + reset_cycles_lp;

    repeat (reset_cycles_lp) @(posedge clk_i);
    @(negedge clk_i);
    check_equal(lce_cmd_v_o, 1'b0, "lce_cmd_v_o in reset");
    check_equal(mem_fwd_v_o, 1'b0, "mem_fwd_v_o in reset");
    rst_n_i     = 1'b1;
    cycle_count = reset_cycles_lp;

    while ((reqs.size() > 0) && !all_done() && (cycle_count < cycle_limit)) begin
      @(negedge clk_i);
      cycle_count++;
      service_cycle();
    end

    if (reqs.size() == 0) begin
      $display("no requests were loaded from the golden file");
      error_count++;
    end else if (!all_done()) begin
      $display("timeout after %0d cycles, %0d commands and %0d memory reads outstanding",
               cycle_count, exp_cmds.size(), exp_fwds.size());
      error_count++;
    end else begin
      // anything sent after the last expected command is an extra
      repeat (drain_cycles_lp) begin
        @(negedge clk_i);
        service_cycle();
      end
    end

    $display("%0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, dut_i.assert_i.fail_count);
    if ((error_count == 0) && (dut_i.assert_i.fail_count == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
